// File: sb_pkg.sv
/* Scoreboard shared types: opcodes, register and data words,
   instruction formats, unit select and row states */
package sb_pkg;

    parameter int N_UNITS = 3;  // ALU, MUL, BRANCH rows

    typedef logic [3:0]  reg_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        ADDI = 4'h5,
        MUL  = 4'h6,
        BEQ  = 4'h7,
        BLT  = 4'h8
    } opcode_e;

    // Register format, low half unused
    typedef struct packed {
        opcode_e     op;
        reg_t        rd;
        reg_t        rs1;
        reg_t        rs2;
        logic [15:0] unused;
    } r_fmt_t;

    typedef struct packed {
        opcode_e            op;
        reg_t               rd;
        reg_t               rs1;
        logic signed [19:0] imm;  // Sign-extended at dispatch
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [1:0] {U_ALU, U_MUL, U_BR} unit_e;  // Also the row index

    typedef enum logic [1:0] {EMPTY, WAIT, RDY, EX} row_state_e;

endpackage

// File: dispatch_if.sv
/* Decoded instruction channel from dispatch to issue */
`timescale 1ns/10ps

interface dispatch_if;

    logic            valid;
    sb_pkg::unit_e   unit;
    sb_pkg::opcode_e op;
    sb_pkg::reg_t    rd, rs1, rs2;
    sb_pkg::word_t   imm;
    logic            use_imm;    // b operand comes from imm
    logic            writes_rd;  // Low for branches
    logic            accept;

    modport src (
        output valid, unit, op, rd, rs1, rs2, imm, use_imm, writes_rd,
        input  accept
    );

    modport dst (
        input  valid, unit, op, rd, rs1, rs2, imm, use_imm, writes_rd,
        output accept
    );

endinterface

// File: wb_if.sv
/* Writeback and unit release events from execute to issue */
`timescale 1ns/10ps

interface wb_if;

    logic                         wb_en;
    sb_pkg::reg_t                 wb_rd;
    sb_pkg::word_t                wb_data;
    logic [sb_pkg::N_UNITS-1:0]   done;  // One bit per unit row

    modport src (
        output wb_en, wb_rd, wb_data, done
    );

    modport dst (
        input  wb_en, wb_rd, wb_data, done
    );

endinterface

// File: regfile.sv
/* Sixteen 32-bit registers, two read ports, one write port, write-through */
`timescale 1ns/10ps

module regfile (
    input  logic          CLK, nRST,
    input  logic          wen,
    input  sb_pkg::reg_t  wsel,
    input  sb_pkg::word_t wdata,
    input  sb_pkg::reg_t  rsel1, rsel2,
    output sb_pkg::word_t rdata1, rdata2
);

    sb_pkg::word_t regs [16];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wen) begin
            regs[wsel] <= wdata;   // r0 is writable like any other
        end
    end

    // Same-cycle write is seen by the readers
    assign rdata1 = (wen && wsel == rsel1) ? wdata : regs[rsel1];
    assign rdata2 = (wen && wsel == rsel2) ? wdata : regs[rsel2];

endmodule

// File: dispatch.sv
/* Dispatch stage: four-phase req/ack capture, instruction decode,
   hold until issue accepts */
`timescale 1ns/10ps

module dispatch (
    input  logic           CLK, nRST,
    input  logic           req,
    input  sb_pkg::instr_u instr,
    output logic           ack,
    dispatch_if.src        dout
);

    sb_pkg::instr_u word;  // Held instruction
    sb_pkg::unit_e  unit;
    logic           held;
    logic           capture;

    assign capture = req && !ack && !held;

    // Four-phase ack and hold state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack  <= 1'b0;
            held <= 1'b0;
        end else begin
            if (capture) begin
                ack  <= 1'b1;
                held <= 1'b1;
            end else begin
                if (ack && !req)
                    ack <= 1'b0;           // Return to zero
                if (held && dout.accept)
                    held <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture)
            word <= instr;
    end

    // Decode the held word
    always_comb begin
        case (word.r_fmt.op)
            sb_pkg::MUL:           unit = sb_pkg::U_MUL;
            sb_pkg::BEQ,
            sb_pkg::BLT:           unit = sb_pkg::U_BR;
            default:               unit = sb_pkg::U_ALU;
        endcase
    end

    assign dout.valid     = held;
    assign dout.unit      = unit;
    assign dout.op        = word.r_fmt.op;
    assign dout.rd        = word.r_fmt.rd;
    assign dout.rs1       = word.r_fmt.rs1;
    assign dout.rs2       = word.r_fmt.rs2;   // Ignored by issue when use_imm
    assign dout.use_imm   = (word.i_fmt.op == sb_pkg::ADDI);
    assign dout.imm       = {{12{word.i_fmt.imm[19]}}, word.i_fmt.imm};
    assign dout.writes_rd = (unit != sb_pkg::U_BR);

endmodule

// File: issue.sv
/* Issue stage: unit status rows, register pending bits, WAW/WAR accept
   checks, oldest-ready selection and operand read */
`timescale 1ns/10ps

module issue #(
    parameter int SEQ_W = 4
) (
    input  logic                        CLK, nRST,
    dispatch_if.dst                     din,
    wb_if.dst                           wb,
    input  logic [sb_pkg::N_UNITS-1:0]  ex_unit_busy,
    output logic                        ex_valid,
    output sb_pkg::unit_e               ex_unit,
    output sb_pkg::opcode_e             ex_op,
    output sb_pkg::reg_t                ex_rd,
    output sb_pkg::word_t               ex_a, ex_b
);

    localparam int NU = sb_pkg::N_UNITS;

    sb_pkg::row_state_e state [NU];
    sb_pkg::opcode_e    row_op [NU];
    sb_pkg::reg_t       row_rd [NU];
    sb_pkg::reg_t       row_rs1 [NU];
    sb_pkg::reg_t       row_rs2 [NU];
    sb_pkg::word_t      row_imm [NU];
    logic [SEQ_W-1:0]   row_seq [NU];
    logic [NU-1:0]      row_use_imm, tag1, tag2;
    logic [SEQ_W-1:0]   seq_ctr;
    logic [15:0]        pending;      // Result status per register
    logic               war, sel_valid, hit1, hit2;
    logic [1:0]         sel;
    sb_pkg::word_t      rdata1, rdata2;

    // Wrap-safe age compare, at most NU sequence numbers are live
    function automatic logic older(input logic [SEQ_W-1:0] a, input logic [SEQ_W-1:0] b);
        logic [SEQ_W-1:0] d;
        d = a - b;
        return d[SEQ_W-1];
    endfunction

    regfile u_regfile (
        .CLK, .nRST,
        .wen(wb.wb_en), .wsel(wb.wb_rd), .wdata(wb.wb_data),
        .rsel1(row_rs1[sel]), .rsel2(row_rs2[sel]),
        .rdata1, .rdata2
    );

    always_comb begin
        war = 1'b0;
        for (int i = 0; i < NU; i++) begin
            if ((state[i] == sb_pkg::WAIT || state[i] == sb_pkg::RDY) &&
                (row_rs1[i] == din.rd || (!row_use_imm[i] && row_rs2[i] == din.rd)))
                war = 1'b1;
        end
        din.accept = din.valid && state[din.unit] == sb_pkg::EMPTY &&
                     !(din.writes_rd && (pending[din.rd] || war));
    end

    // Oldest ready row on an idle unit
    always_comb begin
        sel_valid = 1'b0;
        sel       = '0;
        for (int i = 0; i < NU; i++) begin
            if (state[i] == sb_pkg::RDY && !ex_unit_busy[i] &&
                (!sel_valid || older(row_seq[i], row_seq[sel]))) begin
                sel_valid = 1'b1;
                sel       = 2'(i);
            end
        end
    end

    // A same-cycle writeback is already resolved for the incoming sources
    assign hit1 = wb.wb_en && wb.wb_rd == din.rs1;
    assign hit2 = wb.wb_en && wb.wb_rd == din.rs2;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NU; i++)
                state[i] <= sb_pkg::EMPTY;
            pending  <= '0;
            seq_ctr  <= '0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= sel_valid;
            if (wb.wb_en)
                pending[wb.wb_rd] <= 1'b0;
            if (din.accept) begin
                seq_ctr <= seq_ctr + 1'b1;
                if (din.writes_rd)
                    pending[din.rd] <= 1'b1;
            end
            for (int i = 0; i < NU; i++) begin
                if (din.accept && int'(din.unit) == i)
                    state[i] <= sb_pkg::WAIT;
                else begin
                    case (state[i])
                        sb_pkg::WAIT: if (!tag1[i] && !tag2[i]) state[i] <= sb_pkg::RDY;
                        sb_pkg::RDY:  if (sel_valid && sel == 2'(i)) state[i] <= sb_pkg::EX;
                        sb_pkg::EX:   if (wb.done[i]) state[i] <= sb_pkg::EMPTY;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Row contents, tags and the issue packet
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NU; i++) begin
            if (din.accept && int'(din.unit) == i) begin
                row_op[i]      <= din.op;
                row_rd[i]      <= din.rd;
                row_rs1[i]     <= din.rs1;
                row_rs2[i]     <= din.rs2;
                row_imm[i]     <= din.imm;
                row_use_imm[i] <= din.use_imm;
                row_seq[i]     <= seq_ctr;
                tag1[i]        <= pending[din.rs1] && !hit1;
                tag2[i]        <= !din.use_imm && pending[din.rs2] && !hit2;
            end else if (wb.wb_en) begin
                if (wb.wb_rd == row_rs1[i]) tag1[i] <= 1'b0;   // Wake-up
                if (wb.wb_rd == row_rs2[i]) tag2[i] <= 1'b0;
            end
        end
        if (sel_valid) begin
            ex_unit <= sb_pkg::unit_e'(sel);
            ex_op   <= row_op[sel];
            ex_rd   <= row_rd[sel];
            ex_a    <= rdata1;
            ex_b    <= row_use_imm[sel] ? row_imm[sel] : rdata2;
        end
    end

endmodule

// File: execute.sv
/* Execute stage: ALU, pipelined MUL, branch compare and writeback arbiter */
`timescale 1ns/10ps

module execute #(
    parameter int MUL_LAT = 3
) (
    input  logic                        CLK, nRST,
    input  logic                        ex_valid,
    input  sb_pkg::unit_e               ex_unit,
    input  sb_pkg::opcode_e             ex_op,
    input  sb_pkg::reg_t                ex_rd,
    input  sb_pkg::word_t               ex_a, ex_b,
    output logic [sb_pkg::N_UNITS-1:0]  ex_unit_busy,
    wb_if.src                           wb,
    output logic                        br_valid, br_taken
);

    logic               alu_valid, alu_go, mul_go, mul_wb;
    sb_pkg::reg_t       alu_rd;
    sb_pkg::word_t      alu_res, alu_out;
    logic [MUL_LAT-1:0] mul_v;
    sb_pkg::reg_t       mul_rd [MUL_LAT];
    sb_pkg::word_t      mul_p [MUL_LAT];

    assign alu_go = ex_valid && ex_unit == sb_pkg::U_ALU;
    assign mul_go = ex_valid && ex_unit == sb_pkg::U_MUL;
    assign mul_wb = mul_v[MUL_LAT-1];

    always_comb begin
        case (ex_op)
            sb_pkg::SUB: alu_out = ex_a - ex_b;
            sb_pkg::AND: alu_out = ex_a & ex_b;
            sb_pkg::OR:  alu_out = ex_a | ex_b;
            sb_pkg::XOR: alu_out = ex_a ^ ex_b;
            default:     alu_out = ex_a + ex_b;   // ADD, ADDI
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_valid <= 1'b0;
            mul_v     <= '0;
            br_valid  <= 1'b0;
            br_taken  <= 1'b0;
        end else begin
            if (alu_valid && !mul_wb)
                alu_valid <= 1'b0;                // Written back this cycle
            if (alu_go)
                alu_valid <= 1'b1;
            mul_v    <= {mul_v[MUL_LAT-2:0], mul_go};
            br_valid <= ex_valid && ex_unit == sb_pkg::U_BR;
            br_taken <= (ex_op == sb_pkg::BEQ) ? (ex_a == ex_b) :
                                                 ($signed(ex_a) < $signed(ex_b));
        end
    end

    always_ff @(posedge CLK) begin
        if (alu_go) begin
            alu_rd  <= ex_rd;
            alu_res <= alu_out;
        end
        mul_rd[0] <= ex_rd;
        mul_p[0]  <= ex_a * ex_b;                 // Low 32 bits of product
        for (int s = 1; s < MUL_LAT; s++) begin
            mul_rd[s] <= mul_rd[s-1];
            mul_p[s]  <= mul_p[s-1];
        end
    end

    // MUL has the port first, a waiting ALU result keeps its unit busy
    assign wb.wb_en   = mul_wb || alu_valid;
    assign wb.wb_rd   = mul_wb ? mul_rd[MUL_LAT-1] : alu_rd;
    assign wb.wb_data = mul_wb ? mul_p[MUL_LAT-1] : alu_res;
    assign wb.done    = {br_valid, mul_wb, alu_valid && !mul_wb};

    assign ex_unit_busy[sb_pkg::U_ALU] = alu_go || alu_valid;
    assign ex_unit_busy[sb_pkg::U_MUL] = mul_go || (|mul_v);
    assign ex_unit_busy[sb_pkg::U_BR]  = (ex_valid && ex_unit == sb_pkg::U_BR) || br_valid;

endmodule

// File: sb_core.sv
/* Scoreboard issue subsystem top: dispatch, issue and execute */
`timescale 1ns/10ps

module sb_core #(
    parameter int SEQ_W   = 4,
    parameter int MUL_LAT = 3
) (
    input  logic          CLK, nRST,
    input  logic          instr_req,
    input  logic [31:0]   instr,
    output logic          instr_ack,
    output logic          wb_en,
    output sb_pkg::reg_t  wb_rd,
    output sb_pkg::word_t wb_data,
    output logic          br_valid, br_taken
);

    dispatch_if dif();
    wb_if       wbif();

    logic                       ex_valid;
    sb_pkg::unit_e              ex_unit;
    sb_pkg::opcode_e            ex_op;
    sb_pkg::reg_t               ex_rd;
    sb_pkg::word_t              ex_a, ex_b;
    logic [sb_pkg::N_UNITS-1:0] ex_unit_busy;

    dispatch u_dispatch (
        .CLK, .nRST,
        .req(instr_req), .instr(instr), .ack(instr_ack),
        .dout(dif.src)
    );

    issue #(.SEQ_W(SEQ_W)) u_issue (
        .CLK, .nRST,
        .din(dif.dst), .wb(wbif.dst), .ex_unit_busy,
        .ex_valid, .ex_unit, .ex_op, .ex_rd, .ex_a, .ex_b
    );

    execute #(.MUL_LAT(MUL_LAT)) u_execute (
        .CLK, .nRST,
        .ex_valid, .ex_unit, .ex_op, .ex_rd, .ex_a, .ex_b,
        .ex_unit_busy, .wb(wbif.src), .br_valid, .br_taken
    );

    // Writeback is visible at the top
    assign wb_en   = wbif.wb_en;
    assign wb_rd   = wbif.wb_rd;
    assign wb_data = wbif.wb_data;

endmodule

// File: tb_clock.sv
/* Testbench clock and reset generator */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;   // Release away from the active edge
    end

    always #(PERIOD / 2) CLK = ~CLK;

endmodule

// File: sb_sva.sv
/* Handshake order, X and writeback order assertions, bound to sb_core */
`timescale 1ns/10ps

module sb_sva (
    input  logic                       CLK, nRST,
    input  logic                       instr_req, instr_ack,
    input  logic [31:0]                instr,
    input  logic                       wb_en, br_valid,
    input  sb_pkg::reg_t               wb_rd,
    input  logic [15:0]                pending,
    input  logic [sb_pkg::N_UNITS-1:0] done
);

    // ack only answers a request
    ack_rise: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(instr_ack) |-> $past(instr_req))
        else $error("instr_ack rose without instr_req");

    ack_fall: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(instr_ack) |-> $past(!instr_req))
        else $error("instr_ack fell while instr_req was high");

    instr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        instr_req && !instr_ack |=> $stable(instr))
        else $error("instr changed before instr_ack");

    // A write always retires the one writer in flight for that register
    wb_order: assert property (@(posedge CLK) disable iff (!nRST)
        wb_en |-> pending[wb_rd])
        else $error("wb_rd written with no pending writer");

    no_x: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown({wb_en, br_valid, done}))
        else $error("wb_en, br_valid or done unknown");

endmodule

bind sb_core sb_sva u_sb_sva (
    .CLK, .nRST, .instr_req, .instr, .instr_ack, .wb_en, .br_valid, .wb_rd,
    .pending(u_issue.pending), .done(wbif.done)
);

// File: sb_tb.sv
/* Scoreboard core testbench: in-order reference model, directed and
   random programs, writeback and branch checks */
`timescale 1ns/10ps

module sb_tb;

    localparam int N_SEED  = 16;
    localparam int N_DIR   = 21;
    localparam int N_RAND  = 200;
    localparam int N_INSTR = N_SEED + N_DIR + N_RAND;
    localparam int LIMIT   = 40 * N_INSTR + 100;   // Cycle budget

    typedef logic [31:0] wq_t [$];

    logic          CLK, nRST;
    logic          instr_req, instr_ack;
    logic [31:0]   instr;
    logic          wb_en, br_valid, br_taken;
    sb_pkg::reg_t  wb_rd;
    sb_pkg::word_t wb_data;

    sb_pkg::word_t model [16];   // Register state in program order
    wq_t           exp_q [16];   // Expected writes per register
    logic          br_q [$];
    integer        seed = 32'h67e6;
    int            value_errs = 0;
    int            other_errs = 0;
    int            cycles = 0;
    sb_pkg::word_t exp_val;
    logic          exp_taken;

    tb_clock #(.PERIOD(40), .RST_CYCLES(5)) u_tb_clock (.CLK, .nRST);

    sb_core u_sb_core (
        .CLK, .nRST, .instr_req, .instr, .instr_ack,
        .wb_en, .wb_rd, .wb_data, .br_valid, .br_taken
    );

    function automatic logic [31:0] r_word(input sb_pkg::opcode_e op, input int rd,
                                           input int rs1, input int rs2);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'h0000};
    endfunction

    function automatic logic [31:0] i_word(input int rd, input int rs1, input logic [19:0] imm);
        return {sb_pkg::ADDI, 4'(rd), 4'(rs1), imm};
    endfunction

    // Seed value built from every bit of the register number
    function automatic logic [19:0] fill(input int r);
        logic [3:0] a;
        a = 4'(r);
        return {a, 4'h5, ~a, 4'ha, a};
    endfunction

    function automatic bit queues_empty();
        for (int r = 0; r < 16; r++)
            if (exp_q[r].size() != 0)
                return 1'b0;
        return br_q.size() == 0;
    endfunction

    // Executes one acknowledged word in program order
    task automatic model_step(input logic [31:0] w);
        sb_pkg::opcode_e op;
        logic [31:0]     a, b, imm, res;
        op  = sb_pkg::opcode_e'(w[31:28]);
        a   = model[w[23:20]];
        b   = model[w[19:16]];
        imm = {{12{w[19]}}, w[19:0]};
        if (op == sb_pkg::BEQ || op == sb_pkg::BLT) begin
            br_q.push_back(op == sb_pkg::BEQ ? a == b : $signed(a) < $signed(b));
        end else begin
            case (op)
                sb_pkg::SUB:  res = a - b;
                sb_pkg::AND:  res = a & b;
                sb_pkg::OR:   res = a | b;
                sb_pkg::XOR:  res = a ^ b;
                sb_pkg::ADDI: res = a + imm;
                sb_pkg::MUL:  res = a * b;   // Low word only
                default:      res = a + b;
            endcase
            model[w[27:24]] = res;
            exp_q[w[27:24]].push_back(res);
        end
    endtask

    // Four-phase transfer of one word
    task automatic send_instr(input logic [31:0] w);
        @(negedge CLK);
        instr     = w;
        instr_req = 1'b1;
        do @(negedge CLK); while (!instr_ack);
        model_step(w);
        instr_req = 1'b0;
        do @(negedge CLK); while (instr_ack);
    endtask

    task automatic send_random(input int n);
        logic [31:0] w;
        logic [3:0]  op;
        for (int k = 0; k < n; k++) begin
            w  = $random(seed);
            op = 4'(w[31:4] % 9);
            w  = $random(seed);
            if (op != sb_pkg::ADDI)
                w[15:0] = 16'h0000;
            send_instr({op, w[27:0]});
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // Writeback and branch checks against the queue heads
    always @(posedge CLK) begin
        if (nRST && wb_en) begin
            assert (exp_q[wb_rd].size() > 0) else begin
                $display("Register %0d was written with no write expected", wb_rd);
                other_errs++;
            end
            if (exp_q[wb_rd].size() > 0) begin
                exp_val = exp_q[wb_rd].pop_front();
                assert (wb_data == exp_val) else begin
                    $display("CHECK FAILED wb_data (r%0d) expected %h actual %h",
                             wb_rd, exp_val, wb_data);
                    value_errs++;
                end
            end
        end
        if (nRST && br_valid) begin
            assert (br_q.size() > 0) else begin
                $display("Branch outcome reported with no branch outstanding");
                other_errs++;
            end
            if (br_q.size() > 0) begin
                exp_taken = br_q.pop_front();
                assert (br_taken == exp_taken) else begin
                    $display("CHECK FAILED br_taken expected %h actual %h", exp_taken, br_taken);
                    value_errs++;
                end
            end
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        other_errs++;
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        report_and_finish();
    end

    initial begin
        instr_req = 1'b0;
        instr     = '0;
        for (int r = 0; r < 16; r++)
            model[r] = '0;
        @(posedge nRST);
        @(negedge CLK);
        assert (!instr_ack && !wb_en && !br_valid) else begin
            $display("CHECK FAILED {instr_ack,wb_en,br_valid} expected %h actual %h",
                     3'h0, {instr_ack, wb_en, br_valid});
            value_errs++;
        end
        for (int r = 1; r < 16; r++)
            send_instr(i_word(r, 0, fill(r)));
        send_instr(i_word(0, 0, fill(0)));   // r0 last, the others read it
        // Every ALU opcode
        send_instr(r_word(sb_pkg::ADD, 1, 2, 3));
        send_instr(r_word(sb_pkg::SUB, 4, 5, 6));
        send_instr(r_word(sb_pkg::AND, 7, 8, 9));
        send_instr(r_word(sb_pkg::OR, 10, 11, 12));
        send_instr(r_word(sb_pkg::XOR, 13, 14, 15));
        send_instr(i_word(2, 3, 20'hffffb));
        // RAW chain through the MUL
        send_instr(r_word(sb_pkg::MUL, 5, 1, 4));
        send_instr(r_word(sb_pkg::ADD, 6, 5, 2));
        send_instr(i_word(7, 6, 20'h00123));
        // WAW on r8, then WAR on a source of a waiting MUL
        send_instr(i_word(8, 0, 20'h00007));
        send_instr(i_word(8, 8, 20'h00009));
        send_instr(r_word(sb_pkg::MUL, 9, 8, 10));
        send_instr(i_word(10, 1, 20'h00003));
        // Branches on equal, less and greater operands
        send_instr(i_word(12, 0, 20'h00005));
        send_instr(i_word(13, 12, 20'hffff8));
        send_instr(r_word(sb_pkg::BEQ, 0, 12, 12));
        send_instr(r_word(sb_pkg::BEQ, 0, 12, 13));
        send_instr(r_word(sb_pkg::BLT, 0, 13, 12));
        send_instr(r_word(sb_pkg::BLT, 0, 12, 13));
        send_instr(r_word(sb_pkg::BLT, 0, 12, 12));
        send_instr(r_word(sb_pkg::BEQ, 0, 13, 12));
        send_random(N_RAND);
        while (!queues_empty())
            @(negedge CLK);
        repeat (4) @(negedge CLK);   // A stray late write is still caught
        report_and_finish();
    end

endmodule

// File: src.f
sb_pkg.sv
dispatch_if.sv
wb_if.sv
regfile.sv
dispatch.sv
issue.sv
execute.sv
sb_core.sv
tb_clock.sv
sb_sva.sv
sb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the scoreboard testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module sb_tb -f src.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vsb_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
